//--- hw/spectrum_pkg.sv
`default_nettype none

package spectrum_pkg;

    ////////////////////////////////////////////////////////////
    // Frame geometry
    ////////////////////////////////////////////////////////////

    // Horizontal, in pixels
    localparam int H_ACT   = 64;
    localparam int H_FRONT = 4;
    localparam int H_SYNC  = 8;
    localparam int H_BACK  = 4;
    localparam int H_TOTAL = H_ACT + H_FRONT + H_SYNC + H_BACK;

    // Vertical, in lines
    localparam int V_ACT   = 32;
    localparam int V_FRONT = 1;
    localparam int V_SYNC  = 2;
    localparam int V_BACK  = 1;
    localparam int V_TOTAL = V_ACT + V_FRONT + V_SYNC + V_BACK;

    // Sync windows, counted from the start of the active area
    localparam int H_SYNC_START = H_ACT + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACT + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    localparam int X_BITS = 7;
    localparam int Y_BITS = 6;

    ////////////////////////////////////////////////////////////
    // Bins and magnitudes
    ////////////////////////////////////////////////////////////

    // Two active rows per bin
    localparam int BIN_COUNT = V_ACT / 2;
    localparam int BIN_BITS  = 4;
    localparam int MAG_BITS  = 6;

    ////////////////////////////////////////////////////////////
    // Colours, packed as {r, g, b}
    ////////////////////////////////////////////////////////////

    localparam int COLOR_DEPTH = 8;

    localparam logic [3*COLOR_DEPTH-1:0] BAR_COLOR   = 24'hFF_00_00;
    localparam logic [3*COLOR_DEPTH-1:0] FIELD_COLOR = 24'hFF_FF_FF;
    localparam logic [3*COLOR_DEPTH-1:0] BLANK_COLOR = 24'h00_00_00;

endpackage

`default_nettype wire

//--- hw/raster_if.sv
`timescale 1ns/100ps
`default_nettype none

interface raster_if;

    // Syncs and data enable, all active high
    logic hs;
    logic vs;
    logic de;

    // Position inside the active area, zero during blanking
    logic [spectrum_pkg::X_BITS-1:0] act_x;
    logic [spectrum_pkg::Y_BITS-1:0] act_y;

    // Timing generator side
    modport src
    (
        output hs,
        output vs,
        output de,
        output act_x,
        output act_y
    );

    // Consumers of the raster
    modport snk
    (
        input hs,
        input vs,
        input de,
        input act_x,
        input act_y
    );

endinterface

`default_nettype wire

//--- hw/video_timing.sv
`timescale 1ns/100ps
`default_nettype none

module video_timing
(
    input wire    pix_clk,
    input wire    reset,
    raster_if.src rast
);

    // Position currently presented on the raster outputs
    logic [spectrum_pkg::X_BITS-1:0] h_cnt;
    logic [spectrum_pkg::Y_BITS-1:0] v_cnt;

    // Position for the next cycle
    logic [spectrum_pkg::X_BITS-1:0] h_next;
    logic [spectrum_pkg::Y_BITS-1:0] v_next;

    logic de_next;
    logic hs_next;
    logic vs_next;

    ////////////////////////////////////////////////////////////
    // Counter advance
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        h_next = h_cnt + 1'b1;
        v_next = v_cnt;
        if (h_cnt == spectrum_pkg::H_TOTAL - 1)
        begin
            h_next = '0;
            // Wrap to the top of the active area at end of frame
            if (v_cnt == spectrum_pkg::V_TOTAL - 1)
            begin
                v_next = '0;
            end
            else
            begin
                v_next = v_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode of the next position
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        de_next = (h_next < spectrum_pkg::H_ACT) && (v_next < spectrum_pkg::V_ACT);
        hs_next = (h_next >= spectrum_pkg::H_SYNC_START) &&
                  (h_next < spectrum_pkg::H_SYNC_END);
        vs_next = (v_next >= spectrum_pkg::V_SYNC_START) &&
                  (v_next < spectrum_pkg::V_SYNC_END);
    end

    // Outputs are loaded together with the counters
    always_ff @(posedge pix_clk)
    begin
        if (reset)
        begin
            // Park at the first active pixel
            h_cnt      <= '0;
            v_cnt      <= '0;
            rast.de    <= 1'b1;
            rast.hs    <= 1'b0;
            rast.vs    <= 1'b0;
            rast.act_x <= '0;
            rast.act_y <= '0;
        end
        else
        begin
            h_cnt      <= h_next;
            v_cnt      <= v_next;
            rast.de    <= de_next;
            rast.hs    <= hs_next;
            rast.vs    <= vs_next;
            rast.act_x <= de_next ? h_next : '0;
            rast.act_y <= de_next ? v_next : '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/bin_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module bin_fetch
(
    input  wire                                pix_clk,
    input  wire                                reset,
    raster_if.snk                              rast,
    output logic                               data_req,
    output logic [spectrum_pkg::BIN_BITS-1:0]  bin_index,
    input  wire                                mag_valid,
    input  wire  [spectrum_pkg::MAG_BITS-1:0]  mag,
    output logic                               bin_done,
    output logic                               late,
    output logic                               bar_row,
    output logic [spectrum_pkg::MAG_BITS-1:0]  bar_mag
);

    logic [spectrum_pkg::BIN_BITS-1:0] bin_cnt;
    logic [spectrum_pkg::MAG_BITS-1:0] mag_hold;

    logic vs_d;
    logic pending;
    logic have_mag;

    logic vs_rise;
    logic row_end;
    logic req_evt;
    logic done_evt;
    logic bar_start;
    logic take_mag;

    ////////////////////////////////////////////////////////////
    // Raster events
    ////////////////////////////////////////////////////////////

    assign vs_rise   = rast.vs && !vs_d;
    assign row_end   = rast.de && (rast.act_x == spectrum_pkg::H_ACT - 1);
    // Even row asks, odd row reports
    assign req_evt   = row_end && !rast.act_y[0];
    assign done_evt  = row_end && rast.act_y[0];
    assign bar_start = rast.de && rast.act_y[0] && (rast.act_x == '0);

    // An answer in the bar start cycle itself counts as late
    assign take_mag  = mag_valid && pending && !bar_start;

    always_ff @(posedge pix_clk)
    begin
        if (reset)
        begin
            vs_d      <= 1'b0;
            bin_cnt   <= '0;
            bin_index <= '0;
            data_req  <= 1'b0;
            bin_done  <= 1'b0;
            late      <= 1'b0;
            pending   <= 1'b0;
            have_mag  <= 1'b0;
        end
        else
        begin
            vs_d     <= rast.vs;
            data_req <= req_evt;
            bin_done <= done_evt;
            late     <= bar_start && !have_mag;

            if (req_evt)
            begin
                bin_index <= bin_cnt;
            end

            // Bin count restarts with each frame
            if (vs_rise || (done_evt && (bin_cnt == spectrum_pkg::BIN_COUNT - 1)))
            begin
                bin_cnt <= '0;
            end
            else if (done_evt)
            begin
                bin_cnt <= bin_cnt + 1'b1;
            end

            // Window for the source answer
            if (req_evt)
            begin
                pending <= 1'b1;
            end
            else if (take_mag || bar_start)
            begin
                pending <= 1'b0;
            end

            if (done_evt)
            begin
                have_mag <= 1'b0;
            end
            else if (take_mag)
            begin
                have_mag <= 1'b1;
            end
        end
    end

    always_ff @(posedge pix_clk)
    begin
        if (take_mag)
        begin
            mag_hold <= mag;
        end
    end

    // Bar data follows the raster in the same cycle
    assign bar_row = rast.de && rast.act_y[0];
    assign bar_mag = have_mag ? mag_hold : '0;

endmodule

`default_nettype wire

//--- hw/bar_render.sv
`timescale 1ns/100ps
`default_nettype none

module bar_render
(
    input  wire                                   pix_clk,
    input  wire                                   reset,
    raster_if.snk                                 rast,
    input  wire                                   bar_row,
    input  wire  [spectrum_pkg::MAG_BITS-1:0]     bar_mag,
    output logic                                  hs,
    output logic                                  vs,
    output logic                                  de,
    output logic [spectrum_pkg::COLOR_DEPTH-1:0]  r,
    output logic [spectrum_pkg::COLOR_DEPTH-1:0]  g,
    output logic [spectrum_pkg::COLOR_DEPTH-1:0]  b
);

    localparam int PAD_BITS = spectrum_pkg::X_BITS - spectrum_pkg::MAG_BITS;

    // Bar length widened to the coordinate width
    logic [spectrum_pkg::X_BITS-1:0] bar_len;

    logic [3*spectrum_pkg::COLOR_DEPTH-1:0] pix;

    assign bar_len = {{PAD_BITS{1'b0}}, bar_mag};

    ////////////////////////////////////////////////////////////
    // Colour decision
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        if (!rast.de)
        begin
            pix = spectrum_pkg::BLANK_COLOR;
        end
        else if (bar_row && (rast.act_x < bar_len))
        begin
            // Bar grows from the left edge
            pix = spectrum_pkg::BAR_COLOR;
        end
        else
        begin
            pix = spectrum_pkg::FIELD_COLOR;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    // Syncs travel with the colour so they stay aligned
    always_ff @(posedge pix_clk)
    begin
        if (reset)
        begin
            hs <= 1'b0;
            vs <= 1'b0;
            de <= 1'b0;
        end
        else
        begin
            hs <= rast.hs;
            vs <= rast.vs;
            de <= rast.de;
        end
    end

    always_ff @(posedge pix_clk)
    begin
        {r, g, b} <= pix;
    end

endmodule

`default_nettype wire

//--- hw/spectrum_display.sv
`timescale 1ns/100ps
`default_nettype none

module spectrum_display
(
    input  wire                                   pix_clk,
    input  wire                                   reset,

    // FFT source handshake
    input  wire                                   mag_valid,
    input  wire  [spectrum_pkg::MAG_BITS-1:0]     mag,
    output logic                                  data_req,
    output logic [spectrum_pkg::BIN_BITS-1:0]     bin_index,
    output logic                                  bin_done,
    output logic                                  late,

    // Video out
    output logic                                  hs,
    output logic                                  vs,
    output logic                                  de,
    output logic [spectrum_pkg::COLOR_DEPTH-1:0]  r,
    output logic [spectrum_pkg::COLOR_DEPTH-1:0]  g,
    output logic [spectrum_pkg::COLOR_DEPTH-1:0]  b
);

    logic                              bar_row;
    logic [spectrum_pkg::MAG_BITS-1:0] bar_mag;

    raster_if rast_bus ();

    video_timing video_timing_i
    (
        .pix_clk (pix_clk),
        .reset   (reset),
        .rast    (rast_bus.src)
    );

    // Magnitude fetch for one bin per row pair
    bin_fetch bin_fetch_i
    (
        .pix_clk   (pix_clk),
        .reset     (reset),
        .rast      (rast_bus.snk),
        .data_req  (data_req),
        .bin_index (bin_index),
        .mag_valid (mag_valid),
        .mag       (mag),
        .bin_done  (bin_done),
        .late      (late),
        .bar_row   (bar_row),
        .bar_mag   (bar_mag)
    );

    bar_render bar_render_i
    (
        .pix_clk (pix_clk),
        .reset   (reset),
        .rast    (rast_bus.snk),
        .bar_row (bar_row),
        .bar_mag (bar_mag),
        .hs      (hs),
        .vs      (vs),
        .de      (de),
        .r       (r),
        .g       (g),
        .b       (b)
    );

endmodule

`default_nettype wire

//--- dv/spectrum_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module spectrum_assertions
(
    input wire                               pix_clk,
    input wire                               reset,
    input wire                               data_req,
    input wire [spectrum_pkg::BIN_BITS-1:0]  bin_index,
    input wire                               bin_done,
    input wire                               late,
    input wire [spectrum_pkg::MAG_BITS-1:0]  bar_mag
);

    // Request and done are one-cycle strobes
    req_single: assert property (@(posedge pix_clk) disable iff (reset)
        data_req |=> !data_req)
        else $error("data_req high for more than one cycle");

    done_single: assert property (@(posedge pix_clk) disable iff (reset)
        bin_done |=> !bin_done)
        else $error("bin_done high for more than one cycle");

    // Requests walk through the bins in order, restarting at bin 0
    index_step: assert property (@(posedge pix_clk) disable iff (reset)
        data_req |-> (bin_index == '0) || (bin_index == $past(bin_index) + 1'b1))
        else $error("bin_index skipped a bin between requests");

    // A late bin draws an empty bar
    late_empty: assert property (@(posedge pix_clk) disable iff (reset)
        late |-> (bar_mag == '0))
        else $error("late bin drawn with a non-zero bar");

endmodule

bind bin_fetch spectrum_assertions bin_fetch_assertions_i
(
    .pix_clk   (pix_clk),
    .reset     (reset),
    .data_req  (data_req),
    .bin_index (bin_index),
    .bin_done  (bin_done),
    .late      (late),
    .bar_mag   (bar_mag)
);

`default_nettype wire

//--- dv/spectrum_checker.sv
`timescale 1ns/100ps
`default_nettype none

module spectrum_checker
(
    input wire                                  pix_clk,
    input wire                                  reset,
    input wire                                  data_req,
    input wire [spectrum_pkg::BIN_BITS-1:0]     bin_index,
    input wire                                  bin_done,
    input wire                                  late,
    input wire                                  hs,
    input wire                                  vs,
    input wire                                  de,
    input wire [spectrum_pkg::COLOR_DEPTH-1:0]  r,
    input wire [spectrum_pkg::COLOR_DEPTH-1:0]  g,
    input wire [spectrum_pkg::COLOR_DEPTH-1:0]  b
);

    int frames_done = 0;
    int errors = 0;
    int pixels = 0;
    int frame_errors = 0;

    // Position rebuilt from the output syncs
    int   x;
    int   y;
    int   req_cnt;
    logic done_owed;
    logic de_d;
    logic vs_d;
    logic armed = 1'b0;

    // Raster position counted from the first pixel after reset
    int   hx;
    int   vl;

    task automatic count_error();
        errors++;
        frame_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // FFT source handshake
    ////////////////////////////////////////////////////////////

    task automatic check_handshake();
        if (data_req)
        begin
            if (done_owed)
            begin
                $display("Error: data_req for bin %0d came before the previous bin_done",
                         req_cnt);
                count_error();
            end
            if (bin_index !== req_cnt[spectrum_pkg::BIN_BITS-1:0])
            begin
                $display("Mismatch bin_index: expected %h, actual %h",
                         req_cnt[spectrum_pkg::BIN_BITS-1:0], bin_index);
                count_error();
            end
            req_cnt++;
            done_owed = 1'b1;
        end
        if (bin_done)
        begin
            if (!done_owed)
            begin
                $display("Error: bin_done without an open request");
                count_error();
            end
            done_owed = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Syncs and data enable
    ////////////////////////////////////////////////////////////

    task automatic check_sync();
        logic exp_de;
        logic exp_hs;
        logic exp_vs;
        exp_de = (hx < spectrum_pkg::H_ACT) && (vl < spectrum_pkg::V_ACT);
        exp_hs = (hx >= spectrum_pkg::H_SYNC_START) && (hx < spectrum_pkg::H_SYNC_END);
        exp_vs = (vl >= spectrum_pkg::V_SYNC_START) && (vl < spectrum_pkg::V_SYNC_END);
        if (de !== exp_de)
        begin
            $display("Mismatch de at pixel %0d line %0d: expected %h, actual %h",
                     hx, vl, exp_de, de);
            count_error();
        end
        if (hs !== exp_hs)
        begin
            $display("Mismatch hs at pixel %0d line %0d: expected %h, actual %h",
                     hx, vl, exp_hs, hs);
            count_error();
        end
        if (vs !== exp_vs)
        begin
            $display("Mismatch vs at pixel %0d line %0d: expected %h, actual %h",
                     hx, vl, exp_vs, vs);
            count_error();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Pixel colour and late flag
    ////////////////////////////////////////////////////////////

    task automatic check_pixel();
        logic [3*spectrum_pkg::COLOR_DEPTH-1:0] exp_rgb;
        logic                                   exp_late;
        int                                     bar_len;
        bar_len  = 0;
        exp_late = 1'b0;
        exp_rgb  = spectrum_pkg::BLANK_COLOR;
        if (de)
        begin
            pixels++;
            exp_rgb = spectrum_pkg::FIELD_COLOR;
            // Odd rows carry the bar of bin y/2
            if (y % 2 == 1)
            begin
                if (spectrum_display_tb.sent_ok[y / 2])
                begin
                    bar_len = int'(spectrum_display_tb.sent_mag[y / 2]);
                end
                exp_late = (x == 0) && !spectrum_display_tb.sent_ok[y / 2];
                if (x < bar_len)
                begin
                    exp_rgb = spectrum_pkg::BAR_COLOR;
                end
            end
        end
        if ({r, g, b} !== exp_rgb)
        begin
            $display("Mismatch {r,g,b} at x %0d y %0d: expected %h, actual %h",
                     x, y, exp_rgb, {r, g, b});
            count_error();
        end
        if (late !== exp_late)
        begin
            $display("Mismatch late at x %0d y %0d: expected %h, actual %h",
                     x, y, exp_late, late);
            count_error();
        end
    endtask

    task automatic finish_frame();
        if (req_cnt != spectrum_pkg::BIN_COUNT)
        begin
            $display("Error: %0d data_req pulses in the frame instead of %0d",
                     req_cnt, spectrum_pkg::BIN_COUNT);
            count_error();
        end
        if (done_owed)
        begin
            $display("Error: last bin of the frame never reported bin_done");
            count_error();
        end
        $display("Frame %0d finished with %0d errors", frames_done, frame_errors);
        frames_done++;
        frame_errors = 0;
        req_cnt      = 0;
    endtask

    // Checks start with the first pixel after reset
    always @(posedge pix_clk)
    begin
        armed <= !reset;
    end

    always @(negedge pix_clk)
    begin
        if (!armed)
        begin
            x         = 0;
            y         = 0;
            hx        = 0;
            vl        = 0;
            req_cnt   = 0;
            done_owed = 1'b0;
            de_d      = 1'b0;
            vs_d      = 1'b0;
        end
        else
        begin
            check_handshake();
            check_sync();
            check_pixel();
            if (de)
            begin
                x++;
            end
            else if (de_d)
            begin
                x = 0;
                y++;
            end
            if (vs && !vs_d)
            begin
                finish_frame();
            end
            if (vs)
            begin
                y = 0;
            end
            de_d = de;
            vs_d = vs;
            hx++;
            if (hx == spectrum_pkg::H_TOTAL)
            begin
                hx = 0;
                vl = (vl + 1) % spectrum_pkg::V_TOTAL;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/spectrum_display_tb.sv
`timescale 1ns/100ps
`default_nettype none

module spectrum_display_tb;

    typedef enum logic [1:0] {FIXED, RAMP, RANDOM} mag_mode_t;

    typedef struct packed {
        mag_mode_t                         mode;
        logic [spectrum_pkg::MAG_BITS-1:0] value;
        logic [7:0]                        delay;
        logic [15:0]                       mask;
    } frame_cfg_t;

    // One row per frame, bins set in mask get no answer
    frame_cfg_t frame_table [6] = '{
        '{FIXED,  6'd20, 8'd3,   16'h0000},
        '{RAMP,   6'd0,  8'd1,   16'h0000},
        '{RANDOM, 6'd0,  8'd15,  16'h0000},
        '{FIXED,  6'd40, 8'd100, 16'h0000},
        '{RAMP,   6'd0,  8'd5,   16'h0420},
        '{RANDOM, 6'd0,  8'd16,  16'h0000}
    };

    logic                                 pix_clk;
    logic                                 reset;
    logic                                 mag_valid;
    logic [spectrum_pkg::MAG_BITS-1:0]    mag;
    logic                                 data_req;
    logic [spectrum_pkg::BIN_BITS-1:0]    bin_index;
    logic                                 bin_done;
    logic                                 late;
    logic                                 hs;
    logic                                 vs;
    logic                                 de;
    logic [spectrum_pkg::COLOR_DEPTH-1:0] r;
    logic [spectrum_pkg::COLOR_DEPTH-1:0] g;
    logic [spectrum_pkg::COLOR_DEPTH-1:0] b;

    // What the source sent per bin, and whether it was in time
    logic [spectrum_pkg::MAG_BITS-1:0] sent_mag [spectrum_pkg::BIN_COUNT];
    logic                              sent_ok  [spectrum_pkg::BIN_COUNT];

    frame_cfg_t  cfg;
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;
    int          timeout_cycles = ($size(frame_table) + 1) *
                                  spectrum_pkg::H_TOTAL * spectrum_pkg::V_TOTAL + 2;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    spectrum_display spectrum_display_i
    (
        .pix_clk   (pix_clk),
        .reset     (reset),
        .mag_valid (mag_valid),
        .mag       (mag),
        .data_req  (data_req),
        .bin_index (bin_index),
        .bin_done  (bin_done),
        .late      (late),
        .hs        (hs),
        .vs        (vs),
        .de        (de),
        .r         (r),
        .g         (g),
        .b         (b)
    );

    spectrum_checker checker_i
    (
        .pix_clk   (pix_clk),
        .reset     (reset),
        .data_req  (data_req),
        .bin_index (bin_index),
        .bin_done  (bin_done),
        .late      (late),
        .hs        (hs),
        .vs        (vs),
        .de        (de),
        .r         (r),
        .g         (g),
        .b         (b)
    );

    initial
    begin
        pix_clk = 1'b0;
        forever
        begin
            #50 pix_clk = ~pix_clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // FFT source model
    ////////////////////////////////////////////////////////////

    initial
    begin : source_model
        int idx;
        int delay;
        int ramp;
        forever
        begin
            @(negedge pix_clk);
            if (data_req === 1'b1)
            begin
                idx   = int'(bin_index);
                delay = int'(cfg.delay);
                ramp  = idx * (2 ** spectrum_pkg::MAG_BITS - 1) / (spectrum_pkg::BIN_COUNT - 1);
                case (cfg.mode)
                    FIXED:   sent_mag[idx] = cfg.value;
                    RAMP:    sent_mag[idx] = ramp[spectrum_pkg::MAG_BITS-1:0];
                    default:
                    begin
                        lcg_state     = lcg_next(lcg_state);
                        sent_mag[idx] = lcg_state[31:32-spectrum_pkg::MAG_BITS];
                    end
                endcase
                // Answer must land before the blanking after the request ends
                sent_ok[idx] = !cfg.mask[idx] &&
                               (delay < spectrum_pkg::H_TOTAL - spectrum_pkg::H_ACT);
                if (!cfg.mask[idx])
                begin
                    repeat (delay) @(negedge pix_clk);
                    mag_valid = 1'b1;
                    mag       = sent_mag[idx];
                    @(negedge pix_clk);
                    mag_valid = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame sequence and end of run
    ////////////////////////////////////////////////////////////

    initial
    begin : stimulus
        int i;
        reset     = 1'b1;
        mag_valid = 1'b0;
        mag       = '0;
        cfg       = frame_table[0];
        lcg_state = 32'h4ae4_8170;
        for (i = 0; i < spectrum_pkg::BIN_COUNT; i++)
        begin
            sent_mag[i] = '0;
            sent_ok[i]  = 1'b0;
        end
        repeat (2) @(negedge pix_clk);
        reset = 1'b0;
        for (i = 0; i < $size(frame_table); i++)
        begin
            cfg = frame_table[i];
            wait (checker_i.frames_done == i + 1);
        end
        @(negedge pix_clk);
        $display("Frames %0d, pixels %0d, errors %0d",
                 checker_i.frames_done, checker_i.pixels, checker_i.errors);
        if (checker_i.errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

    always @(posedge pix_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles)
        begin
            $display("Timeout: frames did not complete within %0d cycles", timeout_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- spectrum_display.f
hw/spectrum_pkg.sv
hw/raster_if.sv
hw/video_timing.sv
hw/bin_fetch.sv
hw/bar_render.sv
hw/spectrum_display.sv
dv/spectrum_assertions.sv
dv/spectrum_checker.sv
dv/spectrum_display_tb.sv

//--- Makefile
TOP := spectrum_display_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f spectrum_display.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
